// File: list.f
+incdir+verilog
verilog/sprite_pkg.sv
verilog/sprite_regs.sv
verilog/sprite_line_counter.sv
verilog/sprite_mixer.sv
verilog/sprite_pixel_ram.sv
verilog/sprite_engine.sv
bench/sprite_engine_tb.sv

// File: Bender.yml
package:
  name: sprite_engine

export_include_dirs:
  - verilog

sources:
  - verilog/sprite_pkg.sv
  - verilog/sprite_regs.sv
  - verilog/sprite_line_counter.sv
  - verilog/sprite_mixer.sv
  - verilog/sprite_pixel_ram.sv
  - verilog/sprite_engine.sv
  - target: simulation
    files:
      - bench/sprite_engine_tb.sv

// File: bench/sprite_engine_tb.sv
/* sprite engine testbench */

`timescale 1ns/10ps
`default_nettype none

`include "sprite_config.svh"

module sprite_engine_tb
	import sprite_pkg::*;
();

localparam int SCAN_W = 320;        // partial line for the drawing tests.
localparam int LINE_W = 640;        // whole line for the stream test.
localparam int FILL_IMAGES = 4;
localparam int PIX_WORDS = `SPRITE_WORDS * `IMAGE_COUNT;
localparam int BUS_OPS = FILL_IMAGES * `SPRITE_WORDS + 300;
localparam int PIXELS = (24 + 36 + 48) * (SCAN_W + 4) + 8 * LINE_W;
localparam int LIMIT_CYCLES = BUS_OPS * 12 + PIXELS + 2000;

logic clk_pixel = 1'b0;
logic reset;
logic [`AXI_ADDR_W-1:0] s_awaddr, s_araddr;
logic s_awvalid, s_wvalid, s_bready, s_arvalid, s_rready;
logic s_awready, s_wready, s_bvalid, s_arready, s_rvalid;
logic [31:0] s_wdata, s_rdata;
logic [3:0] s_wstrb;
logic [1:0] s_bresp, s_rresp;
coord_x_t pixel_x;
coord_y_t pixel_y;
logic pixel_valid;
color_t color_out;
logic color_valid;

logic [15:0] lfsr = 16'd18711;
attr_word_t attr_model [0:`SLOT_COUNT-1];      // shadow registers.
color_t bg_model;
color_t mem_model [0:PIX_WORDS-1];             // shadow pixel memory.
logic [4:0] imgs [0:FILL_IMAGES-1];            // images holding data.
logic [1:0] pipe_v = '0;                       // expected beats in flight.
color_t pipe_c [0:1];
int errors = 0;
int checks = 0;
int test_base = 0;

sprite_engine dut0 (.*);

always #10 clk_pixel = ~clk_pixel;

// galois lfsr, one step per bit.
function automatic logic [31:0] random_bits(input int n);
	logic [31:0] r;
	logic b;
	r = '0;
	for (int i = 0; i < n; i++) begin
		b = lfsr[0];
		lfsr = {1'b0, lfsr[15:1]} ^ (b ? 16'hb400 : 16'h0000);
		r = {r[30:0], b};
	end
	return r;
endfunction

// okay for slots, background and pixel writes, slverr elsewhere.
function automatic logic [1:0] map_resp(input logic [16:0] a, input logic wr);
	int w;
	w = a >> 2;
	if (w < `SLOT_COUNT || w == (`BG_OFFSET >> 2)) return 2'b00;
	if (wr && w >= (`PIXMEM_BASE >> 2) && w < (`PIXMEM_BASE >> 2) + PIX_WORDS) return 2'b00;
	return 2'b10;
endfunction

function automatic attr_word_t make_attr(input int x, input int y, input logic [4:0] img);
	attr_word_t a;
	a = '0;
	a[`ATTR_ENABLE] = 1'b1;
	a[`ATTR_X] = coord_x_t'(x);
	a[`ATTR_Y] = coord_y_t'(y);
	a[`ATTR_IMAGE] = img;
	return a;
endfunction

// lowest covering slot wins, colour 0 shows the background.
function automatic color_t predict(input int x, input int y);
	attr_word_t a;
	int dx, dy;
	color_t c;
	for (int i = 0; i < `SLOT_COUNT; i++) begin
		a = attr_model[i];
		dx = x - int'(a[`ATTR_X]);
		dy = y - int'(a[`ATTR_Y]);
		if (a[`ATTR_ENABLE] && dx >= 0 && dx < `SPRITE_SIZE && dy >= 0 && dy < `SPRITE_SIZE) begin
			c = mem_model[int'(a[`ATTR_IMAGE]) * `SPRITE_WORDS + dy * `SPRITE_SIZE + dx];
			return (c != '0) ? c : bg_model;
		end
	end
	return bg_model;
endfunction

task automatic update_model(input int w, input logic [31:0] d, input logic [3:0] strb);
	if (w < `SLOT_COUNT) begin
		for (int b = 0; b < 4; b++) begin
			if (strb[b]) attr_model[w][8*b +: 8] = d[8*b +: 8];
		end
	end else if (w == (`BG_OFFSET >> 2)) begin
		if (strb[0]) bg_model[7:0] = d[7:0];
		if (strb[1]) bg_model[`COLOR_W-1:8] = d[`COLOR_W-1:8];
	end else begin
		mem_model[w - (`PIXMEM_BASE >> 2)] = d[`COLOR_W-1:0];   // pixel window.
	end
endtask

// one write or read, ready held low for a random number of cycles.
task automatic bus_op(input logic wr, input logic [16:0] a, input logic [31:0] d,
		input logic [3:0] strb);
	logic [1:0] exp, resp;
	logic [31:0] exp_d, data;
	int w, waits;
	w = a >> 2;
	exp = map_resp(a, wr);
	exp_d = (w < `SLOT_COUNT) ? attr_model[w % `SLOT_COUNT] : 32'(bg_model);
	if (wr) begin
		s_awaddr = a;
		s_wdata = d;
		s_wstrb = strb;
		s_awvalid = 1'b1;
		s_wvalid = 1'b1;
	end else begin
		s_araddr = a;
		s_arvalid = 1'b1;
	end
	do begin
		@(posedge clk_pixel);
		#2;
	end while (!(s_awready || s_arready));
	if (s_wready !== wr) begin                     // wready rises with awready.
		$display("ERR %0t s_wready got %b exp %b", $time, s_wready, wr);
		errors++;
	end
	@(posedge clk_pixel);                          // handshake edge.
	#2;
	s_awvalid = 1'b0;
	s_wvalid = 1'b0;
	s_arvalid = 1'b0;
	resp = wr ? s_bresp : s_rresp;
	data = s_rdata;
	waits = random_bits(2);
	for (int i = 0; i <= waits; i++) begin
		if (i > 0) begin
			@(posedge clk_pixel);
			#2;
		end
		if (!(wr ? s_bvalid : s_rvalid) || resp !== (wr ? s_bresp : s_rresp) ||
				(!wr && data !== s_rdata)) begin
			$display("response missing or changed while ready was low at %0t", $time);
			errors++;
		end
	end
	checks++;
	if (resp !== exp) begin
		$display("ERR %0t %s got %b exp %b", $time, wr ? "s_bresp" : "s_rresp", resp, exp);
		errors++;
	end else if (!wr && exp == 2'b00 && data !== exp_d) begin
		$display("ERR %0t s_rdata got %h exp %h", $time, data, exp_d);
		errors++;
	end
	if (wr && exp == 2'b00) update_model(w, d, strb);
	s_bready = wr;
	s_rready = !wr;
	@(posedge clk_pixel);
	#2;
	s_bready = 1'b0;
	s_rready = 1'b0;
	if (s_bvalid || s_rvalid) begin
		$display("response still pending after it was accepted at %0t", $time);
		errors++;
	end
endtask

task automatic fill_images();
	color_t c;
	for (int k = 0; k < FILL_IMAGES; k++) begin
		imgs[k] = random_bits(5);
		for (int p = 0; p < `SPRITE_WORDS; p++) begin
			c = random_bits(12);
			if (c == '0) c = 12'h001;                  // keep opaque.
			bus_op(1'b1, `PIXMEM_BASE + 17'(4 * (int'(imgs[k]) * `SPRITE_WORDS + p)),
				32'(c), 4'hf);
		end
	end
endtask

task automatic clear_slots();
	for (int i = 0; i < `SLOT_COUNT; i++) bus_op(1'b1, 17'(4 * i), '0, 4'hf);
endtask

// a line from column 0, then an idle gap.
task automatic scan_line(input int y, input int width, input int gap);
	for (int x = 0; x < width; x++) begin
		pixel_x = coord_x_t'(x);
		pixel_y = coord_y_t'(y);
		pixel_valid = 1'b1;
		@(posedge clk_pixel);
		#2;
	end
	pixel_valid = 1'b0;
	repeat (gap) begin
		@(posedge clk_pixel);
		#2;
	end
endtask

task automatic end_test(input int n, input string name);
	$display("test %0d %s: %0d errors", n, name, errors - test_base);
	test_base = errors;
endtask

// colour and valid compared 3 cycles after the pixel.
always @(posedge clk_pixel) begin
	#1;
	if (color_valid !== pipe_v[1]) begin
		$display("ERR %0t color_valid got %b exp %b", $time, color_valid, pipe_v[1]);
		errors++;
	end else if (pipe_v[1] && color_out !== pipe_c[1]) begin
		$display("ERR %0t color_out got %h exp %h", $time, color_out, pipe_c[1]);
		errors++;
	end
	if (pipe_v[1]) checks++;
	pipe_v[1] = pipe_v[0];
	pipe_c[1] = pipe_c[0];
	pipe_v[0] = reset && pixel_valid;              // pixel sampled at this edge.
	pipe_c[0] = predict(pixel_x, pixel_y);
end

initial begin
	#(LIMIT_CYCLES * 20);
	$display("watchdog: run did not finish within %0d cycles", LIMIT_CYCLES);
	$display("STATUS: FAIL");
	$finish;
end

initial begin
	int sx, sy;
	reset = 1'b0;
	{s_awaddr, s_araddr, s_wdata, s_wstrb} = '0;
	{s_awvalid, s_wvalid, s_bready, s_arvalid, s_rready} = '0;
	pixel_x = '0;
	pixel_y = '0;
	pixel_valid = 1'b0;
	for (int i = 0; i < `SLOT_COUNT; i++) attr_model[i] = '0;
	bg_model = '0;
	repeat (8) @(posedge clk_pixel);
	#2;
	reset = 1'b1;
	for (int i = 0; i <= `SLOT_COUNT; i++) begin   // slots, then background.
		bus_op(1'b1, 17'(4 * i), random_bits(32), 4'hf);
		bus_op(1'b1, 17'(4 * i), random_bits(32), 4'(random_bits(4)));
		bus_op(1'b0, 17'(4 * i), '0, '0);
	end
	end_test(1, "register write and read-back");
	repeat (8) begin
		bus_op(1'b0, `PIXMEM_BASE + 17'(4 * random_bits(13)), '0, '0);
		bus_op(1'b1, 17'h24 + 17'(4 * random_bits(13)), random_bits(32), 4'hf);
		bus_op(1'b0, 17'h24 + 17'(4 * random_bits(13)), '0, '0);
		bus_op(1'b1, 17'h1c800 + 17'(4 * random_bits(11)), random_bits(32), 4'hf);
	end
	for (int i = 0; i <= `SLOT_COUNT; i++) bus_op(1'b0, 17'(4 * i), '0, '0);
	end_test(2, "error responses");
	fill_images();
	clear_slots();
	bus_op(1'b1, `BG_OFFSET, random_bits(12), 4'hf);
	sx = random_bits(8) + random_bits(5);
	sy = random_bits(8) + random_bits(7);
	bus_op(1'b1, 17'(4 * random_bits(3)), make_attr(sx, sy, imgs[random_bits(2)]), 4'hf);
	for (int y = sy - 2; y < sy + 22; y++) scan_line(y, SCAN_W, random_bits(2));
	end_test(3, "single sprite");
	sx = random_bits(8);
	sy = random_bits(8);
	for (int i = 0; i < `SLOT_COUNT; i++) begin   // about three in four enabled.
		bus_op(1'b1, 17'(4 * i), (random_bits(2) != 0) ? make_attr(sx + random_bits(4),
			sy + random_bits(4), imgs[random_bits(2)]) : '0, 4'hf);
	end
	for (int y = sy; y < sy + 36; y++) scan_line(y, SCAN_W, random_bits(2));
	end_test(4, "priority");
	clear_slots();
	sx = random_bits(8) + random_bits(4);
	sy = random_bits(8) + random_bits(4);
	bus_op(1'b1, 17'h0, make_attr(sx, sy, imgs[0]), 4'hf);
	bus_op(1'b1, 17'h4, make_attr(sx + random_bits(4), sy + random_bits(4), imgs[1]), 4'hf);
	repeat (64) begin                               // holes in the top sprite.
		bus_op(1'b1, `PIXMEM_BASE + 17'(4 * (int'(imgs[0]) * `SPRITE_WORDS +
			random_bits(8) + random_bits(7))), '0, 4'hf);
	end
	for (int y = sy - 2; y < sy + 22; y++) scan_line(y, SCAN_W, random_bits(2));
	bus_op(1'b1, 17'h0, {1'b0, attr_model[0][30:0]}, 4'hf);
	for (int y = sy - 2; y < sy + 22; y++) scan_line(y, SCAN_W, random_bits(2));
	end_test(5, "transparency and disable");
	sy = random_bits(8);
	for (int i = 0; i < `SLOT_COUNT; i++) begin
		bus_op(1'b1, 17'(4 * i), make_attr(random_bits(9) + random_bits(6),
			sy + random_bits(3), imgs[random_bits(2)]), 4'hf);
	end
	for (int y = sy; y < sy + 8; y++) scan_line(y, LINE_W, 0);   // back to back.
	repeat (4) @(posedge clk_pixel);
	#2;
	end_test(6, "continuous stream");
	$display("checks %0d errors %0d", checks, errors);
	if (errors == 0) $display("STATUS: PASS");
	else $display("STATUS: FAIL");
	$finish;
end

endmodule

`default_nettype wire

// File: verilog/sprite_engine.sv
/* sprite engine top */

`timescale 1ns/10ps
`default_nettype none

`include "sprite_config.svh"

module sprite_engine
	import sprite_pkg::*;
(
	input  logic                    clk_pixel,
	input  logic                    reset,
	input  logic [`AXI_ADDR_W-1:0]  s_awaddr,
	input  logic                    s_awvalid,
	output logic                    s_awready,
	input  logic [31:0]             s_wdata,
	input  logic [3:0]              s_wstrb,
	input  logic                    s_wvalid,
	output logic                    s_wready,
	output logic [1:0]              s_bresp,
	output logic                    s_bvalid,
	input  logic                    s_bready,
	input  logic [`AXI_ADDR_W-1:0]  s_araddr,
	input  logic                    s_arvalid,
	output logic                    s_arready,
	output logic [31:0]             s_rdata,
	output logic [1:0]              s_rresp,
	output logic                    s_rvalid,
	input  logic                    s_rready,
	input  coord_x_t                pixel_x,
	input  coord_y_t                pixel_y,
	input  logic                    pixel_valid,
	output color_t                  color_out,
	output logic                    color_valid
);

attr_word_t [`SLOT_COUNT-1:0] attr_words;
pix_addr_t [`SLOT_COUNT-1:0] addrs;
logic [`SLOT_COUNT-1:0] hits;
color_t bg_color, ram_wdata, rd_data;
pix_addr_t ram_waddr, rd_addr;
logic ram_we;
logic valid_d1;        // pixel_valid aligned with hits.

sprite_regs regs0 (
	.clk_pixel(clk_pixel), .reset(reset),
	.s_awaddr(s_awaddr), .s_awvalid(s_awvalid), .s_awready(s_awready),
	.s_wdata(s_wdata), .s_wstrb(s_wstrb), .s_wvalid(s_wvalid), .s_wready(s_wready),
	.s_bresp(s_bresp), .s_bvalid(s_bvalid), .s_bready(s_bready),
	.s_araddr(s_araddr), .s_arvalid(s_arvalid), .s_arready(s_arready),
	.s_rdata(s_rdata), .s_rresp(s_rresp), .s_rvalid(s_rvalid), .s_rready(s_rready),
	.attr_words(attr_words), .bg_color(bg_color),
	.ram_we(ram_we), .ram_waddr(ram_waddr), .ram_wdata(ram_wdata)
);

generate
	for (genvar i = 0; i < `SLOT_COUNT; i++) begin : g_slot
		sprite_line_counter line0 (
			.clk_pixel(clk_pixel), .reset(reset),
			.pixel_x(pixel_x), .pixel_y(pixel_y), .pixel_valid(pixel_valid),
			.attr(attr_words[i]), .hit(hits[i]), .addr(addrs[i])
		);
	end
endgenerate

always_ff @(posedge clk_pixel or negedge reset) begin
	if (!reset) valid_d1 <= 1'b0;
	else valid_d1 <= pixel_valid;     // first pipeline stage.
end

sprite_mixer mixer0 (
	.clk_pixel(clk_pixel), .reset(reset),
	.hits(hits), .addrs(addrs), .valid_in(valid_d1), .bg_color(bg_color),
	.rd_addr(rd_addr), .rd_data(rd_data),
	.color_out(color_out), .color_valid(color_valid)
);

sprite_pixel_ram ram0 (
	.clk_pixel(clk_pixel),
	.we(ram_we), .waddr(ram_waddr), .wdata(ram_wdata),
	.raddr(rd_addr), .rdata(rd_data)
);

endmodule

`default_nettype wire

// File: verilog/sprite_pixel_ram.sv
/* sprite pixel memory */

`timescale 1ns/10ps
`default_nettype none

`include "sprite_config.svh"

module sprite_pixel_ram
	import sprite_pkg::*;
(
	input  logic       clk_pixel,
	input  logic       we,
	input  pix_addr_t  waddr,
	input  color_t     wdata,
	input  pix_addr_t  raddr,
	output color_t     rdata
);

localparam int DEPTH = `SPRITE_WORDS * `IMAGE_COUNT;   // 12800 words.

color_t mem [0:DEPTH-1];

always_ff @(posedge clk_pixel) begin
	if (we) mem[waddr] <= wdata;     // bus side.
	rdata <= mem[raddr];              // registered read, one cycle.
end

endmodule

`default_nettype wire

// File: verilog/sprite_mixer.sv
/* sprite priority mixer */

`timescale 1ns/10ps
`default_nettype none

`include "sprite_config.svh"

module sprite_mixer
	import sprite_pkg::*;
(
	input  logic                         clk_pixel,
	input  logic                         reset,
	input  logic [`SLOT_COUNT-1:0]       hits,
	input  pix_addr_t [`SLOT_COUNT-1:0]  addrs,
	input  logic                         valid_in,
	input  color_t                       bg_color,
	output pix_addr_t                    rd_addr,
	input  color_t                       rd_data,
	output color_t                       color_out,
	output logic                         color_valid
);

logic any_hit;
logic hit_d;           // lines up with rd_data.
logic valid_d;

// lowest slot number wins.
always_comb begin
	rd_addr = '0;
	for (int i = `SLOT_COUNT - 1; i >= 0; i--) begin
		if (hits[i]) rd_addr = addrs[i];
	end
end

assign any_hit = |hits;

always_ff @(posedge clk_pixel or negedge reset) begin
	if (!reset) begin
		hit_d <= 1'b0;
		valid_d <= 1'b0;
		color_valid <= 1'b0;
	end else begin
		hit_d <= any_hit;
		valid_d <= valid_in;
		color_valid <= valid_d;
	end
end

// colour 0 is transparent and shows the background.
always_ff @(posedge clk_pixel) begin
	if (hit_d && (rd_data != '0)) color_out <= rd_data;
	else color_out <= bg_color;
end

endmodule

`default_nettype wire

// File: verilog/sprite_line_counter.sv
/* sprite line counter */

`timescale 1ns/10ps
`default_nettype none

`include "sprite_config.svh"

module sprite_line_counter
	import sprite_pkg::*;
(
	input  logic        clk_pixel,
	input  logic        reset,
	input  coord_x_t    pixel_x,
	input  coord_y_t    pixel_y,
	input  logic        pixel_valid,
	input  attr_word_t  attr,
	output logic        hit,
	output pix_addr_t   addr
);

localparam int COL_W = $clog2(`SPRITE_SIZE);
localparam int IMG_W = $clog2(`IMAGE_COUNT);

coord_x_t spr_x, dx;
coord_y_t spr_y, dy;
logic [IMG_W-1:0] image;
logic [COL_W-1:0] col, col_use;
logic in_box;

assign spr_x = attr[`ATTR_X];       // top left corner.
assign spr_y = attr[`ATTR_Y];
assign image = attr[`ATTR_IMAGE];
assign dx = pixel_x - spr_x;        // column inside the box.
assign dy = pixel_y - spr_y;        // row inside the box.

assign in_box = attr[`ATTR_ENABLE] && pixel_valid &&
	(pixel_x >= spr_x) && (dx < coord_x_t'(`SPRITE_SIZE)) &&
	(pixel_y >= spr_y) && (dy < coord_y_t'(`SPRITE_SIZE));

// first column of the box restarts the count at zero.
assign col_use = (dx == '0) ? '0 : col;

always_ff @(posedge clk_pixel or negedge reset) begin
	if (!reset) begin
		hit <= 1'b0;
		col <= '0;
	end else begin
		hit <= in_box;
		if (in_box) begin
			// wraps after the last column, like the 20 state ring.
			col <= (col_use == COL_W'(`SPRITE_SIZE - 1)) ? '0 : col_use + 1'b1;
		end
	end
end

always_ff @(posedge clk_pixel) begin
	addr <= pix_addr_t'(image) * pix_addr_t'(`SPRITE_WORDS) +   // image base.
		pix_addr_t'(dy) * pix_addr_t'(`SPRITE_SIZE) +             // row offset.
		pix_addr_t'(col_use);
end

endmodule

`default_nettype wire

// File: verilog/sprite_regs.sv
/* sprite register block */

`timescale 1ns/10ps
`default_nettype none

`include "sprite_config.svh"

module sprite_regs
	import sprite_pkg::*;
(
	input  logic                          clk_pixel,
	input  logic                          reset,
	input  logic [`AXI_ADDR_W-1:0]        s_awaddr,
	input  logic                          s_awvalid,
	output logic                          s_awready,
	input  logic [31:0]                   s_wdata,
	input  logic [3:0]                    s_wstrb,
	input  logic                          s_wvalid,
	output logic                          s_wready,
	output logic [1:0]                    s_bresp,
	output logic                          s_bvalid,
	input  logic                          s_bready,
	input  logic [`AXI_ADDR_W-1:0]        s_araddr,
	input  logic                          s_arvalid,
	output logic                          s_arready,
	output logic [31:0]                   s_rdata,
	output logic [1:0]                    s_rresp,
	output logic                          s_rvalid,
	input  logic                          s_rready,
	output attr_word_t [`SLOT_COUNT-1:0]  attr_words,
	output color_t                        bg_color,
	output logic                          ram_we,
	output pix_addr_t                     ram_waddr,
	output color_t                        ram_wdata
);

localparam int WORD_W = `AXI_ADDR_W - 2;
localparam int SLOT_IW = $clog2(`SLOT_COUNT);
localparam logic [WORD_W-1:0] BG_WORD = WORD_W'(`BG_OFFSET >> 2);
localparam logic [WORD_W-1:0] PIX_FIRST = WORD_W'(`PIXMEM_BASE >> 2);
localparam logic [WORD_W-1:0] PIX_LAST = WORD_W'((`PIXMEM_BASE >> 2) +
	`SPRITE_WORDS * `IMAGE_COUNT - 1);
localparam logic [1:0] RESP_OKAY = 2'b00;
localparam logic [1:0] RESP_SLVERR = 2'b10;

logic [WORD_W-1:0] aw_word, ar_word, pix_word;
logic [SLOT_IW-1:0] aw_idx, ar_idx;
logic aw_slot, aw_bg, aw_pix, ar_slot, ar_bg;
logic idle, wr_start, rd_start, wr_hs, rd_hs;

assign aw_word = s_awaddr[`AXI_ADDR_W-1:2];   // byte lanes ignored, word decode.
assign ar_word = s_araddr[`AXI_ADDR_W-1:2];
assign aw_idx = aw_word[SLOT_IW-1:0];
assign ar_idx = ar_word[SLOT_IW-1:0];
assign aw_slot = aw_word < WORD_W'(`SLOT_COUNT);     // 0x00 to 0x1c.
assign ar_slot = ar_word < WORD_W'(`SLOT_COUNT);
assign aw_bg = aw_word == BG_WORD;
assign ar_bg = ar_word == BG_WORD;
assign aw_pix = (aw_word >= PIX_FIRST) && (aw_word <= PIX_LAST);   // write only window.
assign pix_word = aw_word - PIX_FIRST;

// one transaction at a time, nothing new while a response waits.
assign idle = !s_awready && !s_arready && !s_bvalid && !s_rvalid;
assign wr_start = idle && s_awvalid && s_wvalid;      // needs aw and w together.
assign rd_start = idle && s_arvalid && !wr_start;     // writes win a tie.
assign wr_hs = s_awready && s_awvalid && s_wvalid;
assign rd_hs = s_arready && s_arvalid;

always_ff @(posedge clk_pixel or negedge reset) begin
	if (!reset) begin
		s_awready <= 1'b0;
		s_wready <= 1'b0;
		s_arready <= 1'b0;
		s_bvalid <= 1'b0;
		s_bresp <= RESP_OKAY;
		s_rvalid <= 1'b0;
		s_rresp <= RESP_OKAY;
		ram_we <= 1'b0;
	end else begin
		s_awready <= wr_start;            // single cycle ready pulse.
		s_wready <= wr_start;
		s_arready <= rd_start;
		ram_we <= wr_hs && aw_pix;        // one strobe per pixel write.
		if (wr_hs) begin
			s_bvalid <= 1'b1;
			s_bresp <= (aw_slot || aw_bg || aw_pix) ? RESP_OKAY : RESP_SLVERR;
		end else if (s_bready) begin
			s_bvalid <= 1'b0;               // held until accepted.
		end
		if (rd_hs) begin
			s_rvalid <= 1'b1;
			s_rresp <= (ar_slot || ar_bg) ? RESP_OKAY : RESP_SLVERR;   // pixel reads fail.
		end else if (s_rready) begin
			s_rvalid <= 1'b0;
		end
	end
end

always_ff @(posedge clk_pixel or negedge reset) begin
	if (!reset) begin
		attr_words <= '0;                 // all slots disabled.
		bg_color <= '0;
	end else if (wr_hs) begin
		if (aw_slot) begin
			for (int b = 0; b < 4; b++) begin
				if (s_wstrb[b]) attr_words[aw_idx][8*b +: 8] <= s_wdata[8*b +: 8];
			end
		end
		if (aw_bg) begin
			if (s_wstrb[0]) bg_color[7:0] <= s_wdata[7:0];
			if (s_wstrb[1]) bg_color[`COLOR_W-1:8] <= s_wdata[`COLOR_W-1:8];
		end
	end
end

always_ff @(posedge clk_pixel) begin
	if (wr_hs) begin
		ram_waddr <= pix_word[`ADDR_W-1:0];       // byte offset to word index.
		ram_wdata <= s_wdata[`COLOR_W-1:0];
	end
	if (rd_hs) begin
		if (ar_slot) s_rdata <= attr_words[ar_idx];
		else if (ar_bg) s_rdata <= 32'(bg_color);
		else s_rdata <= '0;
	end
end

endmodule

`default_nettype wire

// File: verilog/sprite_pkg.sv
/* sprite engine types */

`default_nettype none

`include "sprite_config.svh"

package sprite_pkg;

	typedef logic [`X_W-1:0]     coord_x_t;    // screen column.
	typedef logic [`Y_W-1:0]     coord_y_t;    // screen line.
	typedef logic [`ADDR_W-1:0]  pix_addr_t;   // pixel memory address.
	typedef logic [`COLOR_W-1:0] color_t;      // one rgb444 pixel.
	typedef logic [31:0]         attr_word_t;  // enable, corner and image of a slot.

endpackage

`default_nettype wire

// File: verilog/sprite_config.svh
/* sprite engine configuration */

`ifndef SPRITE_CONFIG_SVH
`define SPRITE_CONFIG_SVH

// sprite geometry.
`define SPRITE_SIZE   20      // edge of a sprite in pixels.
`define SPRITE_WORDS  400     // pixels per image.
`define SLOT_COUNT    8       // sprite slots on screen.
`define IMAGE_COUNT   32      // images held in pixel memory.

// datapath widths.
`define ADDR_W        14      // pixel memory word address.
`define X_W           10      // screen column.
`define Y_W           9       // screen line.
`define COLOR_W       12      // rgb444.

// bus address map, byte offsets.
`define AXI_ADDR_W    17
`define PIXMEM_BASE   17'h10000   // first pixel word.
`define BG_OFFSET     17'h00020   // background colour register.

// attribute word fields.
`define ATTR_ENABLE   31
`define ATTR_X        27:18
`define ATTR_Y        17:9
`define ATTR_IMAGE    4:0

`endif
